//--- hw/radio_pkg.sv
package radio_pkg;

   //////////////////////////////////////////////////////////////////////
   // bus and sample widths
   localparam int WB_ADR_W  = 4;    // wishbone word address
   localparam int WB_DAT_W  = 32;   // wishbone data
   localparam int DAC_W     = 14;   // dac word
   localparam int ADC_W     = 12;   // adc word

   //////////////////////////////////////////////////////////////////////
   // spi master
   localparam int SPI_BITS  = 16;   // bits per transfer
   localparam int SPI_DIV   = 4;    // clk_fpga cycles per half sclk
   localparam int SPI_NSEL  = 3;    // peripherals on the shared bus
   localparam int SEL_W     = 2;    // peripheral index width
   localparam int SPI_DIV_W = $clog2(SPI_DIV);
   localparam int SPI_CNT_W = $clog2(SPI_BITS);

   localparam logic [SPI_DIV_W-1:0] DIV_LAST = SPI_DIV_W'(SPI_DIV - 1);  // half period end
   localparam logic [SPI_CNT_W-1:0] BIT_LAST = SPI_CNT_W'(SPI_BITS - 1); // final bit

   localparam logic [SEL_W-1:0] SEL_CODEC = 2'd0;  // ad9862 style codec
   localparam logic [SEL_W-1:0] SEL_TX_DB = 2'd1;  // tx daughterboard
   localparam logic [SEL_W-1:0] SEL_RX_DB = 2'd2;  // rx daughterboard

   //////////////////////////////////////////////////////////////////////
   // register map, word addresses
   localparam logic [WB_ADR_W-1:0] REG_TX_I      = 4'd0;  // dac i word
   localparam logic [WB_ADR_W-1:0] REG_TX_Q      = 4'd1;  // dac q word
   localparam logic [WB_ADR_W-1:0] REG_SPI_SEL   = 4'd2;  // peripheral index
   localparam logic [WB_ADR_W-1:0] REG_SPI_DATA  = 4'd3;  // wr starts, rd reply
   localparam logic [WB_ADR_W-1:0] REG_STATUS    = 4'd4;  // busy and seen flags
   localparam logic [WB_ADR_W-1:0] REG_RX_SAMPLE = 4'd5;  // last adc pair

   // field positions
   localparam int STAT_BUSY = 0;    // spi transfer running
   localparam int STAT_SEEN = 1;    // rx pair since last sample read
   localparam int RX_I_LSB  = 0;    // i in the low half
   localparam int RX_Q_LSB  = 16;   // q in the high half

endpackage

//--- hw/radio_core.sv
`timescale 1ns/10ps

module radio_core import radio_pkg::*;
  (
   input  logic                clk_fpga,
   input  logic                rst_n_i,          // board reset, async
   output logic                rst_sync_n_o,     // released 2 edges late

   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   input  logic [WB_ADR_W-1:0] wb_adr_i,
   input  logic [WB_DAT_W-1:0] wb_dat_i,
   output logic                wb_ack_o,
   output logic [WB_DAT_W-1:0] wb_dat_o,

   output logic                spi_start_o,      // one cycle pulse
   output logic [SEL_W-1:0]    spi_sel_o,
   output logic [SPI_BITS-1:0] spi_tx_data_o,
   input  logic                spi_busy_i,
   input  logic [SPI_BITS-1:0] spi_rx_data_i,

   output logic [DAC_W-1:0]    tx_i_o,
   output logic [DAC_W-1:0]    tx_q_o,

   input  logic [ADC_W-1:0]    rx_i_i,
   input  logic [ADC_W-1:0]    rx_q_i,
   input  logic                rx_valid_i
  );

   logic                rst_meta;     // first sync stage
   logic                rst_sync_n;   // second stage, local reset
   logic                ack_q;
   logic [WB_DAT_W-1:0] dat_q;
   logic                access;       // new cycle seen this clock
   logic                wr_en;
   logic                rd_en;
   logic [WB_DAT_W-1:0] rd_data;
   logic [DAC_W-1:0]    tx_i_q;
   logic [DAC_W-1:0]    tx_q_q;
   logic [SEL_W-1:0]    sel_q;
   logic                start_q;
   logic [SPI_BITS-1:0] tx_word_q;
   logic                seen_q;       // sticky, cleared by sample read
   logic [ADC_W-1:0]    rx_i_q;
   logic [ADC_W-1:0]    rx_q_q;

   //////////////////////////////////////////////////////////////////////
   // reset synchronizer
   always_ff @(posedge clk_fpga or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rst_meta   <= 1'b0;               // assert at once
         rst_sync_n <= 1'b0;
      end
      else
      begin
         rst_meta   <= 1'b1;
         rst_sync_n <= rst_meta;           // release on 2nd edge
      end
   end

   //////////////////////////////////////////////////////////////////////
   // wishbone classic slave
   assign access = wb_cyc_i & wb_stb_i & ~ack_q;   // no back to back ack
   assign wr_en  = access & wb_we_i;
   assign rd_en  = access & ~wb_we_i;

   always_comb
   begin
      rd_data = '0;                        // unmapped reads zero
      case (wb_adr_i)
         REG_TX_I      : rd_data[DAC_W-1:0] = tx_i_q;
         REG_TX_Q      : rd_data[DAC_W-1:0] = tx_q_q;
         REG_SPI_SEL   : rd_data[SEL_W-1:0] = sel_q;
         REG_SPI_DATA  : rd_data[SPI_BITS-1:0] = spi_rx_data_i;
         REG_STATUS    :
         begin
            rd_data[STAT_BUSY] = spi_busy_i;
            rd_data[STAT_SEEN] = seen_q;
         end
         REG_RX_SAMPLE :
         begin
            rd_data[RX_I_LSB +: ADC_W] = rx_i_q;
            rd_data[RX_Q_LSB +: ADC_W] = rx_q_q;
         end
         default       : rd_data = '0;
      endcase
   end

   always_ff @(posedge clk_fpga or negedge rst_sync_n)
   begin
      if (!rst_sync_n)
      begin
         ack_q   <= 1'b0;
         dat_q   <= '0;
         tx_i_q  <= '0;
         tx_q_q  <= '0;
         sel_q   <= '0;
         start_q <= 1'b0;
         seen_q  <= 1'b0;
      end
      else
      begin
         ack_q   <= access;                // ack one clock after stb
         start_q <= wr_en && (wb_adr_i == REG_SPI_DATA) && !spi_busy_i;  // drop if busy
         if (access)
            dat_q <= rd_data;              // held while ack is high
         if (wr_en)
         begin
            case (wb_adr_i)
               REG_TX_I    : tx_i_q <= wb_dat_i[DAC_W-1:0];
               REG_TX_Q    : tx_q_q <= wb_dat_i[DAC_W-1:0];
               REG_SPI_SEL : sel_q  <= wb_dat_i[SEL_W-1:0];
               default     : ;             // others are read only
            endcase
         end
         if (rx_valid_i)
            seen_q <= 1'b1;                // new pair wins over clear
         else if (rd_en && (wb_adr_i == REG_RX_SAMPLE))
            seen_q <= 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // spi word and rx capture
   always_ff @(posedge clk_fpga)
   begin
      if (wr_en && (wb_adr_i == REG_SPI_DATA) && !spi_busy_i)
         tx_word_q <= wb_dat_i[SPI_BITS-1:0];   // travels with start
      if (rx_valid_i)
      begin
         rx_i_q <= rx_i_i;
         rx_q_q <= rx_q_i;
      end
   end

   assign rst_sync_n_o  = rst_sync_n;
   assign wb_ack_o      = ack_q;
   assign wb_dat_o      = dat_q;
   assign spi_start_o   = start_q;
   assign spi_sel_o     = sel_q;
   assign spi_tx_data_o = tx_word_q;
   assign tx_i_o        = tx_i_q;
   assign tx_q_o        = tx_q_q;

endmodule

//--- hw/spi_master.sv
`timescale 1ns/10ps

module spi_master import radio_pkg::*;
  (
   input  logic                clk_fpga,
   input  logic                rst_n_i,

   input  logic                start_i,        // one cycle, ignored when busy
   input  logic [SEL_W-1:0]    sel_i,          // peripheral index
   input  logic [SPI_BITS-1:0] tx_data_i,
   output logic                busy_o,
   output logic [SPI_BITS-1:0] rx_data_o,      // valid once busy drops

   output logic [SPI_NSEL-1:0] sclk_o,
   output logic [SPI_NSEL-1:0] mosi_o,
   output logic [SPI_NSEL-1:0] sen_o,          // active low enables
   input  logic [SPI_NSEL-1:0] miso_i
  );

   logic [SPI_NSEL-1:0]  sen_dec;    // decoded enables for next transfer
   logic [SPI_NSEL-1:0]  sen_q;
   logic                 busy_q;
   logic                 sclk_q;     // mode 0, idle low
   logic [SPI_DIV_W-1:0] div_cnt;
   logic [SPI_CNT_W-1:0] bit_cnt;
   logic [SPI_BITS-1:0]  shift_tx;
   logic [SPI_BITS-1:0]  shift_rx;
   logic [SPI_BITS-1:0]  rx_word;
   logic                 half_end;   // last cycle of a half period
   logic                 last_bit;
   logic                 rise;       // sclk goes high this edge
   logic                 fall;       // sclk goes low this edge
   logic                 miso;       // from the enabled peripheral only

   //////////////////////////////////////////////////////////////////////
   // enable decode, out of range index selects nobody
   always_comb
   begin
      for (int k = 0; k < SPI_NSEL; k++)
      begin
         sen_dec[k] = (sel_i != SEL_W'(k));
      end
   end

   assign half_end = busy_q & (div_cnt == DIV_LAST);
   assign last_bit = (bit_cnt == BIT_LAST);
   assign rise     = half_end & ~sclk_q;
   assign fall     = half_end & sclk_q;

   //////////////////////////////////////////////////////////////////////
   // divider, bit counter and enables
   always_ff @(posedge clk_fpga or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         busy_q  <= 1'b0;
         sen_q   <= '1;                      // all deselected
         sclk_q  <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= '0;
      end
      else if (!busy_q)
      begin
         if (start_i)
         begin
            busy_q  <= 1'b1;                 // busy and enable together
            sen_q   <= sen_dec;
            div_cnt <= '0;
            bit_cnt <= '0;
         end
      end
      else
      begin
         div_cnt <= div_cnt + 1'b1;
         if (half_end)
         begin
            div_cnt <= '0;
            sclk_q  <= ~sclk_q;
            if (sclk_q)                      // falling edge
            begin
               if (last_bit)
               begin
                  busy_q <= 1'b0;            // done with sclk low
                  sen_q  <= '1;
               end
               else
                  bit_cnt <= bit_cnt + 1'b1;
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // shift registers
   always_ff @(posedge clk_fpga)
   begin
      if (!busy_q && start_i)
         shift_tx <= tx_data_i;              // msb out before first rise
      else if (fall)
         shift_tx <= {shift_tx[SPI_BITS-2:0], 1'b0};   // next bit on fall
      if (rise)
         shift_rx <= {shift_rx[SPI_BITS-2:0], miso};   // sample on rise
      if (fall && last_bit)
         rx_word <= shift_rx;                // full word by last rise
   end

   // shared bus gating, idle peripherals held at 0
   assign miso      = |(~sen_q & miso_i);
   assign sclk_o    = ~sen_q & {SPI_NSEL{sclk_q}};
   assign mosi_o    = ~sen_q & {SPI_NSEL{shift_tx[SPI_BITS-1]}};
   assign sen_o     = sen_q;
   assign busy_o    = busy_q;
   assign rx_data_o = rx_word;

endmodule

//--- hw/codec_tx_interleave.sv
`timescale 1ns/10ps

module codec_tx_interleave import radio_pkg::*;
  (
   input  logic             clk_fpga,
   input  logic             rst_n_i,
   input  logic [DAC_W-1:0] tx_i_i,      // held register values
   input  logic [DAC_W-1:0] tx_q_i,
   output logic [DAC_W-1:0] dac_o,       // i then q, one word per clock
   output logic             dac_sync_o   // high on the i word
  );

   logic [DAC_W-1:0] i_q;                // registered copies
   logic [DAC_W-1:0] q_q;
   logic             phase_q;            // 0 = i slot next
   logic [DAC_W-1:0] dac_q;
   logic             sync_q;

   always_ff @(posedge clk_fpga)
   begin
      i_q <= tx_i_i;
      q_q <= tx_q_i;
   end

   //////////////////////////////////////////////////////////////////////
   // phase flop and output mux
   always_ff @(posedge clk_fpga or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         phase_q <= 1'b0;
         dac_q   <= '0;
         sync_q  <= 1'b0;
      end
      else
      begin
         phase_q <= ~phase_q;            // alternate every clock
         dac_q   <= phase_q ? q_q : i_q;
         sync_q  <= ~phase_q;            // marks the i phase
      end
   end

   assign dac_o      = dac_q;
   assign dac_sync_o = sync_q;

endmodule

//--- hw/codec_rx_deinterleave.sv
`timescale 1ns/10ps

module codec_rx_deinterleave import radio_pkg::*;
  (
   input  logic             clk_fpga,
   input  logic             rst_n_i,
   input  logic [ADC_W-1:0] adc_i,       // interleaved i/q words
   input  logic             adc_sync_i,  // high on the i word
   output logic [ADC_W-1:0] rx_i_o,
   output logic [ADC_W-1:0] rx_q_o,
   output logic             rx_valid_o   // one cycle per pair
  );

   logic [ADC_W-1:0] i_hold;             // i waiting for its q
   logic             have_i;
   logic [ADC_W-1:0] rx_i_q;
   logic [ADC_W-1:0] rx_q_q;
   logic             valid_q;
   logic             pair_done;          // q word arriving after an i

   assign pair_done = have_i & ~adc_sync_i;

   //////////////////////////////////////////////////////////////////////
   // pairing state
   always_ff @(posedge clk_fpga or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         have_i  <= 1'b0;
         valid_q <= 1'b0;
      end
      else
      begin
         valid_q <= pair_done;           // strobe after q is sampled
         if (adc_sync_i)
            have_i <= 1'b1;              // restart on every sync word
         else if (have_i)
            have_i <= 1'b0;              // pair complete
      end
   end

   // payload path
   always_ff @(posedge clk_fpga)
   begin
      if (adc_sync_i)
         i_hold <= adc_i;
      if (pair_done)
      begin
         rx_i_q <= i_hold;
         rx_q_q <= adc_i;
      end
   end

   assign rx_i_o     = rx_i_q;
   assign rx_q_o     = rx_q_q;
   assign rx_valid_o = valid_q;

endmodule

//--- hw/radio_top.sv
`timescale 1ns/10ps

module radio_top import radio_pkg::*;
  (
   input  logic                clk_fpga,
   input  logic                rst_n_i,

   // host register bus
   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   input  logic [WB_ADR_W-1:0] wb_adr_i,
   input  logic [WB_DAT_W-1:0] wb_dat_i,
   output logic                wb_ack_o,
   output logic [WB_DAT_W-1:0] wb_dat_o,

   // codec, tx db, rx db spi
   output logic [SPI_NSEL-1:0] spi_sclk_o,
   output logic [SPI_NSEL-1:0] spi_mosi_o,
   output logic [SPI_NSEL-1:0] spi_sen_o,
   input  logic [SPI_NSEL-1:0] spi_miso_i,

   // codec data buses
   output logic [DAC_W-1:0]    dac_o,
   output logic                dac_sync_o,
   input  logic [ADC_W-1:0]    adc_i,
   input  logic                adc_sync_i
  );

   logic                rst_sync_n;
   logic                spi_start;
   logic [SEL_W-1:0]    spi_sel;
   logic [SPI_BITS-1:0] spi_tx_data;
   logic                spi_busy;
   logic [SPI_BITS-1:0] spi_rx_data;
   logic [DAC_W-1:0]    tx_i;
   logic [DAC_W-1:0]    tx_q;
   logic [ADC_W-1:0]    rx_i;
   logic [ADC_W-1:0]    rx_q;
   logic                rx_valid;

   //////////////////////////////////////////////////////////////////////
   // registers and reset
   radio_core u_core
     (.clk_fpga(clk_fpga), .rst_n_i(rst_n_i), .rst_sync_n_o(rst_sync_n),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
      .spi_start_o(spi_start), .spi_sel_o(spi_sel), .spi_tx_data_o(spi_tx_data),
      .spi_busy_i(spi_busy), .spi_rx_data_i(spi_rx_data),
      .tx_i_o(tx_i), .tx_q_o(tx_q),
      .rx_i_i(rx_i), .rx_q_i(rx_q), .rx_valid_i(rx_valid));

   // shared spi bus
   spi_master u_spi
     (.clk_fpga(clk_fpga), .rst_n_i(rst_sync_n),
      .start_i(spi_start), .sel_i(spi_sel), .tx_data_i(spi_tx_data),
      .busy_o(spi_busy), .rx_data_o(spi_rx_data),
      .sclk_o(spi_sclk_o), .mosi_o(spi_mosi_o), .sen_o(spi_sen_o),
      .miso_i(spi_miso_i));

   //////////////////////////////////////////////////////////////////////
   // codec paths
   codec_tx_interleave u_tx
     (.clk_fpga(clk_fpga), .rst_n_i(rst_sync_n),
      .tx_i_i(tx_i), .tx_q_i(tx_q),
      .dac_o(dac_o), .dac_sync_o(dac_sync_o));

   codec_rx_deinterleave u_rx
     (.clk_fpga(clk_fpga), .rst_n_i(rst_sync_n),
      .adc_i(adc_i), .adc_sync_i(adc_sync_i),
      .rx_i_o(rx_i), .rx_q_o(rx_q), .rx_valid_o(rx_valid));

endmodule

//--- tb/radio_assertions.sv
`timescale 1ns/10ps

module radio_assertions import radio_pkg::*;
  (
   input logic                clk_fpga,
   input logic                rst_sync_n,   // core reset after sync
   input logic                wb_ack_o,
   input logic [SPI_NSEL-1:0] spi_sen_o,
   input logic [SPI_NSEL-1:0] spi_sclk_o,
   input logic                dac_sync_o
  );

   int fail_cnt = 0;                        // failed assertion count

   //////////////////////////////////////////////////////////////////////
   // bus and spi rules
   ack_one_cycle : assert property (@(posedge clk_fpga) disable iff (!rst_sync_n)
      wb_ack_o |=> !wb_ack_o)
      else
      begin
         $error("wb ack held longer than one cycle");
         fail_cnt++;
      end

   one_enable : assert property (@(posedge clk_fpga) disable iff (!rst_sync_n)
      $onehot0(~spi_sen_o))                    // at most one low
      else
      begin
         $error("more than one spi enable active");
         fail_cnt++;
      end

   idle_sclk : assert property (@(posedge clk_fpga) disable iff (!rst_sync_n)
      (spi_sclk_o & spi_sen_o) == '0)          // deselected stays low
      else
      begin
         $error("sclk toggles on an idle peripheral");
         fail_cnt++;
      end

   // dac phase skips first cycle after release
   dac_alternate : assert property (@(posedge clk_fpga) disable iff (!rst_sync_n)
      $past(rst_sync_n) |-> (dac_sync_o != $past(dac_sync_o)))
      else
      begin
         $error("dac sync did not alternate");
         fail_cnt++;
      end

endmodule

bind radio_top radio_assertions u_assertions
  (.clk_fpga(clk_fpga), .rst_sync_n(rst_sync_n), .wb_ack_o(wb_ack_o),
   .spi_sen_o(spi_sen_o), .spi_sclk_o(spi_sclk_o), .dac_sync_o(dac_sync_o));

//--- tb/radio_tb.sv
`timescale 1ns/10ps

//////////////////////////////////////////////////////////////////////
// spi peripheral model replying with pattern xor previous word
module spi_periph_model import radio_pkg::*;
  #(parameter logic [SEL_W-1:0] IDX = 2'd0)
  (
   input  logic                sclk_i,
   input  logic                mosi_i,
   input  logic                sen_i,       // active low
   output logic                miso_o,
   output logic [SPI_BITS-1:0] word_o,      // last word received
   output int                  xfer_o,      // completed transfers
   output int                  edges_o      // sclk rises seen at all
  );

   logic [SPI_BITS-1:0] out_sr;
   logic [SPI_BITS-1:0] in_sr;
   logic [SPI_BITS-1:0] last;             // reply lags one transfer
   logic                active;

   initial
   begin
      miso_o  = 1'b0;
      word_o  = '0;
      xfer_o  = 0;
      edges_o = 0;
      last    = '0;
      in_sr   = '0;
      active  = 1'b0;
   end

   always @(negedge sen_i)
   begin
      active = 1'b1;
      out_sr = {8'hA5, 6'd0, IDX} ^ last;  // msb ready before first rise
      miso_o = out_sr[SPI_BITS-1];
   end

   always @(negedge sclk_i)
   begin
      if (!sen_i)
      begin
         out_sr = out_sr << 1;             // next bit on fall
         miso_o = out_sr[SPI_BITS-1];
      end
   end

   always @(posedge sclk_i)
   begin
      edges_o = edges_o + 1;
      if (!sen_i)
         in_sr = {in_sr[SPI_BITS-2:0], mosi_i};
   end

   always @(posedge sen_i)
   begin
      if (active)                          // skip x to 1 at reset
      begin
         word_o = in_sr;
         last   = in_sr;
         xfer_o = xfer_o + 1;
         active = 1'b0;
      end
   end

endmodule

module radio_tb import radio_pkg::*; ();

   localparam int NUM_TESTS   = 5;
   localparam int CLK_NS      = 8;
   localparam int XFER_CYC    = SPI_BITS * 2 * SPI_DIV;
   localparam int WATCHDOG_NS = NUM_TESTS * XFER_CYC * CLK_NS * 4;

   logic                          clk_fpga;
   logic                          rst_n_i;
   logic                          wb_cyc;
   logic                          wb_stb;
   logic                          wb_we;
   logic [WB_ADR_W-1:0]           wb_adr;
   logic [WB_DAT_W-1:0]           wb_dat;
   logic                          wb_ack_o;
   logic [WB_DAT_W-1:0]           wb_dat_o;
   logic [SPI_NSEL-1:0]           spi_sclk_o;
   logic [SPI_NSEL-1:0]           spi_mosi_o;
   logic [SPI_NSEL-1:0]           spi_sen_o;
   logic [SPI_NSEL-1:0]           spi_miso;
   logic [DAC_W-1:0]              dac_o;
   logic                          dac_sync_o;
   logic [ADC_W-1:0]              adc;
   logic                          adc_sync;
   logic [SPI_NSEL-1:0][SPI_BITS-1:0] model_word;
   int                            model_xfer [SPI_NSEL];
   int                            model_edges [SPI_NSEL];

   int                  seed;
   int                  errors;
   int                  checks;
   int                  tnum;
   int                  test_err;              // errors at test start
   logic                dac_watch;
   logic                last_sync;
   logic [DAC_W-1:0]    exp_i;
   logic [DAC_W-1:0]    exp_q;
   logic [SPI_BITS-1:0] prev_word [SPI_NSEL];  // what each model got last

   always #(CLK_NS/2) clk_fpga = ~clk_fpga;

   radio_top dut
     (.clk_fpga(clk_fpga), .rst_n_i(rst_n_i),
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat),
      .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
      .spi_sclk_o(spi_sclk_o), .spi_mosi_o(spi_mosi_o), .spi_sen_o(spi_sen_o),
      .spi_miso_i(spi_miso),
      .dac_o(dac_o), .dac_sync_o(dac_sync_o),
      .adc_i(adc), .adc_sync_i(adc_sync));

   spi_periph_model #(.IDX(SEL_CODEC)) m_codec
     (.sclk_i(spi_sclk_o[0]), .mosi_i(spi_mosi_o[0]), .sen_i(spi_sen_o[0]),
      .miso_o(spi_miso[0]), .word_o(model_word[0]),
      .xfer_o(model_xfer[0]), .edges_o(model_edges[0]));
   spi_periph_model #(.IDX(SEL_TX_DB)) m_txdb
     (.sclk_i(spi_sclk_o[1]), .mosi_i(spi_mosi_o[1]), .sen_i(spi_sen_o[1]),
      .miso_o(spi_miso[1]), .word_o(model_word[1]),
      .xfer_o(model_xfer[1]), .edges_o(model_edges[1]));
   spi_periph_model #(.IDX(SEL_RX_DB)) m_rxdb
     (.sclk_i(spi_sclk_o[2]), .mosi_i(spi_mosi_o[2]), .sen_i(spi_sen_o[2]),
      .miso_o(spi_miso[2]), .word_o(model_word[2]),
      .xfer_o(model_xfer[2]), .edges_o(model_edges[2]));

   //////////////////////////////////////////////////////////////////////
   // reference and compare tasks
   function automatic logic [SPI_BITS-1:0] ref_spi_reply(input logic [SEL_W-1:0] idx,
                                                         input logic [SPI_BITS-1:0] prev);
      return {8'hA5, 6'd0, idx} ^ prev;    // index pattern xor last word
   endfunction

   task automatic check_word(input string what, input logic [WB_DAT_W-1:0] got,
                             input logic [WB_DAT_W-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_dac(input logic [DAC_W-1:0] got, input logic [DAC_W-1:0] exp,
                            input logic sync_got, input logic sync_exp);
      checks++;
      if (got !== exp || sync_got !== sync_exp)
      begin
         errors++;
         $display("[ERROR] %0t: dac got %h sync %b expected %h sync %b",
                  $time, got, sync_got, exp, sync_exp);
      end
   endtask

   task automatic check_pair(input logic [ADC_W-1:0] got_i, input logic [ADC_W-1:0] got_q,
                             input logic [ADC_W-1:0] exp_i_w, input logic [ADC_W-1:0] exp_q_w);
      checks++;
      if (got_i !== exp_i_w || got_q !== exp_q_w)
      begin
         errors++;
         $display("[ERROR] %0t: rx pair got %h/%h expected %h/%h",
                  $time, got_i, got_q, exp_i_w, exp_q_w);
      end
   endtask

   // dac compare process sampled mid cycle
   always @(negedge clk_fpga)
   begin
      if (dac_watch)
         check_dac(dac_o, dac_sync_o ? exp_i : exp_q, dac_sync_o, ~last_sync);
      last_sync = dac_sync_o;
   end

   //////////////////////////////////////////////////////////////////////
   // host and stimulus tasks
   task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                             input logic [WB_DAT_W-1:0] dat, output logic [WB_DAT_W-1:0] rdata);
      int n;
      n = 0;
      @(negedge clk_fpga);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = we;
      wb_adr = adr;
      wb_dat = dat;
      do
      begin
         @(negedge clk_fpga);
         n++;
      end
      while (!wb_ack_o && n < 20);               // ack bounded wait
      if (!wb_ack_o)
      begin
         errors++;
         $display("no wishbone ack from address %0d", adr);
      end
      rdata  = wb_dat_o;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_reg(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
      logic [WB_DAT_W-1:0] unused;
      bus_access(1'b1, adr, dat, unused);
   endtask

   task automatic read_reg(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] dat);
      bus_access(1'b0, adr, '0, dat);
   endtask

   task automatic wait_spi_idle();
      logic [WB_DAT_W-1:0] st;
      int n;
      n = 0;
      do
      begin
         read_reg(REG_STATUS, st);
         n++;
      end
      while (st[STAT_BUSY] && n < 2 * XFER_CYC);
      if (st[STAT_BUSY])
      begin
         errors++;
         $display("spi busy never cleared");
      end
   endtask

   task automatic drive_adc(input logic [ADC_W-1:0] data, input logic sync);
      @(negedge clk_fpga);
      adc      = data;
      adc_sync = sync;
   endtask

   task automatic end_test(input string name);
      tnum++;
      $display("test %0d %s %s", tnum, name, (errors == test_err) ? "ok" : "mismatch");
      test_err = errors;
   endtask

   // one transfer to idx with data, reply and bus isolation checks
   task automatic spi_xfer(input logic [SEL_W-1:0] idx);
      logic [WB_DAT_W-1:0] rd;
      logic [SPI_BITS-1:0] w;
      int e [SPI_NSEL];
      int x;
      write_reg(REG_SPI_SEL, 32'(idx));
      for (int k = 0; k < SPI_NSEL; k++)
         e[k] = model_edges[k];
      x = model_xfer[idx];
      w = SPI_BITS'($random(seed));
      write_reg(REG_SPI_DATA, 32'(w));
      wait_spi_idle();
      check_word("model word", 32'(model_word[idx]), 32'(w));
      check_word("model xfers", 32'(model_xfer[idx]), 32'(x + 1));
      read_reg(REG_SPI_DATA, rd);
      check_word("spi reply", rd, 32'(ref_spi_reply(idx, prev_word[idx])));
      prev_word[idx] = w;
      for (int k = 0; k < SPI_NSEL; k++)
         check_word("sclk edges", 32'(model_edges[k]), 32'(e[k] + ((k == idx) ? SPI_BITS : 0)));
   endtask

   //////////////////////////////////////////////////////////////////////
   // watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout after %0d ns, tests did not finish", WATCHDOG_NS);
      $display("*** FAILED ***");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // main sequence
   initial
   begin
      logic [WB_DAT_W-1:0] r;
      logic [WB_DAT_W-1:0] rd;
      logic [ADC_W-1:0]    ai;
      logic [ADC_W-1:0]    aq;
      logic [SPI_BITS-1:0] w1;
      int                  x;
      seed      = 94;
      errors    = 0;
      checks    = 0;
      tnum      = 0;
      test_err  = 0;
      clk_fpga  = 1'b0;
      rst_n_i   = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat    = '0;
      adc       = '0;
      adc_sync  = 1'b0;
      dac_watch = 1'b0;
      last_sync = 1'b0;
      exp_i     = '0;
      exp_q     = '0;
      for (int k = 0; k < SPI_NSEL; k++)
         prev_word[k] = '0;
      repeat (10) @(negedge clk_fpga);
      rst_n_i = 1'b1;
      repeat (3) @(negedge clk_fpga);            // sync release plus one

      // reset state
      check_word("enables", 32'(spi_sen_o), 32'(3'b111));
      check_word("sclk", 32'(spi_sclk_o), 32'd0);
      read_reg(REG_STATUS, rd);
      check_word("status", rd, 32'd0);
      read_reg(REG_TX_I, rd);
      check_word("tx_i", rd, 32'd0);
      read_reg(REG_TX_Q, rd);
      check_word("tx_q", rd, 32'd0);
      read_reg(REG_SPI_SEL, rd);
      check_word("spi_sel", rd, 32'd0);
      end_test("reset state");

      // register readback masked to field widths
      repeat (4)
      begin
         r = $random(seed);
         write_reg(REG_TX_I, r);
         read_reg(REG_TX_I, rd);
         check_word("tx_i rb", rd, r & ((32'd1 << DAC_W) - 1));
         r = $random(seed);
         write_reg(REG_TX_Q, r);
         read_reg(REG_TX_Q, rd);
         check_word("tx_q rb", rd, r & ((32'd1 << DAC_W) - 1));
         r = $random(seed);
         write_reg(REG_SPI_SEL, r);
         read_reg(REG_SPI_SEL, rd);
         check_word("sel rb", rd, r & ((32'd1 << SEL_W) - 1));
      end
      for (int a = 6; a < 16; a++)
      begin
         write_reg(WB_ADR_W'(a), $random(seed));
         read_reg(WB_ADR_W'(a), rd);
         check_word("unmapped", rd, 32'd0);
      end
      end_test("readback");

      // dac interleave
      exp_i = DAC_W'($random(seed));
      exp_q = DAC_W'($random(seed));
      write_reg(REG_TX_I, 32'(exp_i));
      write_reg(REG_TX_Q, 32'(exp_q));
      repeat (3) @(negedge clk_fpga);           // allowed latency
      dac_watch = 1'b1;
      repeat (20) @(negedge clk_fpga);
      dac_watch = 1'b0;
      end_test("dac interleave");

      // spi to each peripheral and then a write while busy
      spi_xfer(SEL_CODEC);
      spi_xfer(SEL_TX_DB);
      spi_xfer(SEL_RX_DB);
      write_reg(REG_SPI_SEL, 32'(SEL_TX_DB));
      x  = model_xfer[1];
      w1 = SPI_BITS'($random(seed));
      write_reg(REG_SPI_DATA, 32'(w1));
      read_reg(REG_STATUS, rd);
      check_word("busy", rd, 32'd1);
      write_reg(REG_SPI_DATA, $random(seed));   // must be dropped
      wait_spi_idle();
      check_word("busy word", 32'(model_word[1]), 32'(w1));
      read_reg(REG_SPI_DATA, rd);
      check_word("busy reply", rd, 32'(ref_spi_reply(SEL_TX_DB, prev_word[1])));
      prev_word[1] = w1;
      repeat (10) @(negedge clk_fpga);
      check_word("busy xfers", 32'(model_xfer[1]), 32'(x + 1));
      check_word("enables idle", 32'(spi_sen_o), 32'(3'b111));
      end_test("spi transfers");

      // adc deinterleave
      ai = '0;
      aq = '0;
      repeat (6)
      begin
         ai = ADC_W'($random(seed));
         aq = ADC_W'($random(seed));
         drive_adc(ai, 1'b1);
         drive_adc(aq, 1'b0);
      end
      drive_adc('0, 1'b0);
      drive_adc('0, 1'b0);
      read_reg(REG_STATUS, rd);
      check_word("seen set", rd, 32'd1 << STAT_SEEN);
      read_reg(REG_RX_SAMPLE, rd);
      check_pair(rd[RX_I_LSB +: ADC_W], rd[RX_Q_LSB +: ADC_W], ai, aq);
      read_reg(REG_STATUS, rd);
      check_word("seen clear", rd, 32'd0);
      drive_adc(ADC_W'($random(seed)), 1'b1);   // orphan i word
      ai = ADC_W'($random(seed));
      aq = ADC_W'($random(seed));
      drive_adc(ai, 1'b1);                       // restarts the pair
      drive_adc(aq, 1'b0);
      drive_adc('0, 1'b0);
      drive_adc('0, 1'b0);
      read_reg(REG_RX_SAMPLE, rd);
      check_pair(rd[RX_I_LSB +: ADC_W], rd[RX_Q_LSB +: ADC_W], ai, aq);
      end_test("adc deinterleave");

      errors = errors + dut.u_assertions.fail_cnt;   // bound checker failures
      $display("tests %0d  checks %0d  errors %0d", tnum, checks, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- all.f
hw/radio_pkg.sv
hw/radio_core.sv
hw/spi_master.sv
hw/codec_tx_interleave.sv
hw/codec_rx_deinterleave.sv
hw/radio_top.sv
tb/radio_assertions.sv
tb/radio_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= radio_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
